/* files.f */
+incdir+include
rtl/dma_pkg.sv
rtl/stride_addr_gen.sv
rtl/ext_xfer_engine.sv
rtl/int_mem.sv
rtl/dma_top.sv
verif/ext_bus_model.sv
verif/dma_tb.sv

/* Bender.yml */
package:
  name: strided_dma

export_include_dirs:
  - include

sources:
  - files:
      - rtl/dma_pkg.sv
      - rtl/stride_addr_gen.sv
      - rtl/ext_xfer_engine.sv
      - rtl/int_mem.sv
      - rtl/dma_top.sv
  - target: any(test, simulation)
    files:
      - verif/ext_bus_model.sv
      - verif/dma_tb.sv

/* verif/dma_tb.sv */
`default_nettype none

`include "dma_macros.svh"

module dma_tb
   import dma_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_XFERS = 7;
   localparam int MAX_BEATS = 1 << `DMA_INT_ADDR_W;

   typedef struct packed {
      dma_cfg_t    cfg;
      logic        stall;
      logic        rerun;
      logic [31:0] seed;
   } xfer_entry_t;

   logic        rst;
   logic        clk;
   logic        run;
   logic        done;
   dma_cfg_t    cfg;
   mem_req_t    host_req;
   word_t       host_rdata;
   logic        bus_valid;
   logic        bus_ready;
   logic        bus_we;
   ext_addr_t   bus_addr;
   word_t       bus_wdata;
   word_t       bus_rdata;
   logic        stall;
   logic        stall_en;
   logic [31:0] ready_state = 32'd26;
   xfer_entry_t xfers [NUM_XFERS];
   ext_addr_t   exp_addr [MAX_BEATS];
   word_t       exp_data [MAX_BEATS];
   int          errors;
   int          total_beats;
   logic        table_ready = 1'b0;

   dma_top u_dut (
      .rst(rst), .clk(clk), .run(run), .done(done), .cfg(cfg),
      .host_req(host_req), .host_rdata(host_rdata),
      .bus_valid(bus_valid), .bus_ready(bus_ready), .bus_we(bus_we),
      .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_rdata(bus_rdata)
   );

   ext_bus_model u_bus (
      .rst(rst), .clk(clk), .stall(stall), .valid(bus_valid), .ready(bus_ready),
      .we(bus_we), .addr(bus_addr), .wdata(bus_wdata), .rdata(bus_rdata)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic dma_cfg_t make_cfg(input ext_addr_t ext, input int_addr_t ia,
         input len_t len, input dma_dir_e dir, input ext_addr_t start, input stride_t incr,
         input stride_t shift, input period_t period);
      dma_cfg_t c;
      c.ext_addr      = ext;
      c.int_addr      = ia;
      c.length        = len;
      c.dir           = dir;
      c.stride.start  = start;
      c.stride.incr   = incr;
      c.stride.shift  = shift;
      c.stride.period = period;
      return c;
   endfunction

   task automatic fill_table();
      xfers[0] = '{make_cfg(16'h1000, 8'h10, 9'd16, DIR_EXT2INT, 16'h0000, 16'sd1, 16'sd0,
                            8'd0), 1'b0, 1'b0, 32'd0};
      xfers[1] = '{make_cfg(16'h2000, 8'h40, 9'd24, DIR_INT2EXT, 16'h0100, -16'sd2, 16'sd32,
                            8'd5), 1'b0, 1'b0, 32'd1};
      // Same transfers again under random stalls
      xfers[2] = '{xfers[0].cfg, 1'b1, 1'b0, 32'd2};
      xfers[3] = '{xfers[1].cfg, 1'b1, 1'b0, 32'd3};
      xfers[4] = '{make_cfg(16'h1800, 8'h80, 9'd20, DIR_EXT2INT, 16'h0004, 16'sd1, 16'sd0,
                            8'd0), 1'b1, 1'b1, 32'd4};
      xfers[5] = '{make_cfg(16'h3000, 8'hff, 9'd1, DIR_EXT2INT, 16'h0005, 16'sd3, 16'sd0,
                            8'd0), 1'b0, 1'b0, 32'd5};
      xfers[6] = '{make_cfg(16'h8000, 8'h00, 9'd256, DIR_INT2EXT, 16'h0000, 16'sd1, -16'sd4,
                            8'd16), 1'b1, 1'b0, 32'd6};
      total_beats = 0;
      for (int i = 0; i < NUM_XFERS; i++) begin
         total_beats += xfers[i].cfg.length;
      end
      table_ready = 1'b1;
   endtask

   // Expected offsets add incr each beat and shift after every period beats
   task automatic build_addr_list(input dma_cfg_t c);
      ext_addr_t off;
      period_t   phase;
      off   = c.stride.start;
      phase = '0;
      for (int k = 0; k < c.length; k++) begin
         exp_addr[k] = c.ext_addr + off;
         off = off + c.stride.incr;
         if (c.stride.period != 0) begin
            if (phase == c.stride.period - 1) begin
               off   = off + c.stride.shift;
               phase = '0;
            end else begin
               phase = phase + 1'b1;
            end
         end
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
      assert (got === exp) else begin
         errors++;
         $display("FAIL %s expected %h got %h", name, exp, got);
      end
   endtask

   task automatic host_write(input int_addr_t a, input word_t w);
      @(posedge rst);
      host_req <= '{en: 1'b1, we: 1'b1, addr: a, wdata: w};
   endtask

   task automatic host_read(input int_addr_t a, output word_t w);
      @(posedge rst);
      host_req <= '{en: 1'b1, we: 1'b0, addr: a, wdata: '0};
      @(posedge rst);
      host_req <= '0;
      @(negedge rst);
      w = host_rdata;
   endtask

   task automatic run_xfer(input xfer_entry_t e);
      @(posedge rst);
      cfg      <= e.cfg;
      run      <= 1'b1;
      stall_en <= e.stall;
      @(posedge rst);
      run <= 1'b0;
      @(negedge rst);
      check_word("done", 32'd0, 32'(done));
      if (e.rerun) begin
         // Second pulse while busy must be ignored
         repeat (4) @(posedge rst);
         run <= 1'b1;
         @(posedge rst);
         run <= 1'b0;
      end
      while (!done) begin
         @(negedge rst);
      end
      @(posedge rst);
      stall_en <= 1'b0;
   endtask

   task automatic apply_entry(input xfer_entry_t e);
      logic [31:0] s;
      word_t       got;
      build_addr_list(e.cfg);
      s = 32'd26 + e.seed;
      for (int k = 0; k < e.cfg.length; k++) begin
         s = lcg_next(s);
         exp_data[k] = s;
      end
      u_bus.clear_log();
      if (e.cfg.dir == DIR_EXT2INT) begin
         for (int k = 0; k < e.cfg.length; k++) begin
            u_bus.preload(exp_addr[k], exp_data[k]);
         end
      end else begin
         for (int k = 0; k < e.cfg.length; k++) begin
            host_write(int_addr_t'(e.cfg.int_addr + k), exp_data[k]);
         end
         @(posedge rst);
         host_req <= '0;
      end
      run_xfer(e);
      check_word("u_bus.beats", 32'(e.cfg.length), u_bus.beats);
      for (int k = 0; k < e.cfg.length; k++) begin
         check_word($sformatf("bus_addr[%0d]", k), 32'(exp_addr[k]), 32'(u_bus.addr_log[k]));
         if (e.cfg.dir == DIR_EXT2INT) begin
            host_read(int_addr_t'(e.cfg.int_addr + k), got);
            check_word($sformatf("host_rdata[%0d]", k), exp_data[k], got);
         end else begin
            check_word($sformatf("bus_wdata[%0d]", k), exp_data[k], u_bus.data_log[k]);
         end
      end
   endtask

   initial begin
      rst = 1'b0;
      forever #10 rst = ~rst;
   end

   always @(posedge rst) begin
      ready_state <= lcg_next(ready_state);
      stall       <= stall_en && ready_state[16];
   end

   initial begin
      wait (table_ready);
      repeat (total_beats * 40 + 1000) @(posedge rst);
      $display("Timeout: transfers did not finish in time, %0d errors so far", errors);
      $display("Test failures found");
      $finish;
   end

   initial begin
      errors   = 0;
      clk      = 1'b1;
      run      = 1'b0;
      cfg      = '0;
      host_req = '0;
      stall    = 1'b0;
      stall_en = 1'b0;
      fill_table();
      repeat (8) @(posedge rst);
      clk <= 1'b0;
      @(negedge rst);
      check_word("done", 32'd1, 32'(done));
      check_word("bus_valid", 32'd0, 32'(bus_valid));
      for (int i = 0; i < NUM_XFERS; i++) begin
         apply_entry(xfers[i]);
      end
      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verif/ext_bus_model.sv */
`default_nettype none

`include "dma_macros.svh"

module ext_bus_model
   import dma_pkg::*;
(
   input  wire logic      rst,
   input  wire logic      clk,
   input  wire logic      stall,
   input  wire logic      valid,
   output logic           ready,
   input  wire logic      we,
   input  wire ext_addr_t addr,
   input  wire word_t     wdata,
   output word_t          rdata
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int EXT_DEPTH = 1 << `DMA_EXT_ADDR_W;
   localparam int LOG_DEPTH = 1 << `DMA_LEN_W;

   word_t     mem [EXT_DEPTH];
   ext_addr_t addr_log [LOG_DEPTH];
   word_t     data_log [LOG_DEPTH];
   int        beats;

   // Stall pattern comes from the testbench LCG
   assign ready = !stall;

   always @(posedge rst or posedge clk) begin
      if (clk) begin
         rdata <= '0;
      end else if (valid && ready) begin
         addr_log[beats] <= addr;
         data_log[beats] <= we ? wdata : mem[addr];
         beats <= beats + 1;
         if (we) begin
            mem[addr] <= wdata;
         end else begin
            // Read word shows up one cycle after acceptance
            rdata <= mem[addr];
         end
      end
   end

   task automatic preload(input ext_addr_t a, input word_t w);
      mem[a] = w;
   endtask

   task automatic clear_log();
      beats = 0;
   endtask

endmodule

`default_nettype wire

/* rtl/dma_top.sv */
`default_nettype none

`include "dma_macros.svh"

module dma_top
   import dma_pkg::*;
(
   input  wire logic      rst,
   input  wire logic      clk,
   input  wire logic      run,
   output logic           done,
   input  wire dma_cfg_t  cfg,
   input  wire mem_req_t  host_req,
   output word_t          host_rdata,
   output logic           bus_valid,
   input  wire logic      bus_ready,
   output logic           bus_we,
   output ext_addr_t      bus_addr,
   output word_t          bus_wdata,
   input  wire word_t     bus_rdata
);

   logic      gen_init;
   logic      gen_step;
   ext_addr_t ext_offset;
   mem_req_t  mem_req;
   word_t     mem_rdata;

   ext_xfer_engine u_engine (
      .rst        (rst),
      .clk        (clk),
      .run        (run),
      .done       (done),
      .cfg        (cfg),
      .gen_init   (gen_init),
      .gen_step   (gen_step),
      .ext_offset (ext_offset),
      .bus_valid  (bus_valid),
      .bus_ready  (bus_ready),
      .bus_we     (bus_we),
      .bus_addr   (bus_addr),
      .bus_wdata  (bus_wdata),
      .bus_rdata  (bus_rdata),
      .mem_req    (mem_req),
      .mem_rdata  (mem_rdata)
   );

   stride_addr_gen u_addr_gen (
      .rst    (rst),
      .clk    (clk),
      .init   (gen_init),
      .step   (gen_step),
      .cfg    (cfg.stride),
      .offset (ext_offset)
   );

   // Port A for the engine, port B for the host
   int_mem u_mem (
      .rst     (rst),
      .port_a  (mem_req),
      .rdata_a (mem_rdata),
      .port_b  (host_req),
      .rdata_b (host_rdata)
   );

endmodule

`default_nettype wire

/* rtl/int_mem.sv */
`default_nettype none

`include "dma_macros.svh"

module int_mem
   import dma_pkg::*;
(
   input  wire logic     rst,
   input  wire mem_req_t port_a,
   output word_t         rdata_a,
   input  wire mem_req_t port_b,
   output word_t         rdata_b
);

   localparam int DEPTH = 1 << `DMA_INT_ADDR_W;

   word_t mem [DEPTH];

   // Read returns the old word on a same-port write
   always_ff @(posedge rst) begin
      if (port_a.en) begin
         if (port_a.we) begin
            mem[port_a.addr] <= port_a.wdata;
         end
         rdata_a <= mem[port_a.addr];
      end
      if (port_b.en) begin
         if (port_b.we) begin
            mem[port_b.addr] <= port_b.wdata;
         end
         rdata_b <= mem[port_b.addr];
      end
   end

   // Host and engine must not collide on a write
   a_no_dual_write: assert property (
      @(posedge rst)
      !(port_a.en && port_a.we && port_b.en && port_b.we &&
        (port_a.addr == port_b.addr))
   );

endmodule

`default_nettype wire

/* rtl/ext_xfer_engine.sv */
`default_nettype none

`include "dma_macros.svh"

module ext_xfer_engine
   import dma_pkg::*;
(
   input  wire logic      rst,
   input  wire logic      clk,
   input  wire logic      run,
   output logic           done,
   input  wire dma_cfg_t  cfg,
   output logic           gen_init,
   output logic           gen_step,
   input  wire ext_addr_t ext_offset,
   output logic           bus_valid,
   input  wire logic      bus_ready,
   output logic           bus_we,
   output ext_addr_t      bus_addr,
   output word_t          bus_wdata,
   input  wire word_t     bus_rdata,
   output mem_req_t       mem_req,
   input  wire word_t     mem_rdata
);

   xfer_state_e state_q;
   xfer_state_e state_d;

   // Accepted bus beats and issued internal reads
   len_t beat_q;
   len_t rd_idx_q;

   logic      valid_q;
   logic      wr_pend_q;
   logic      fresh_q;
   int_addr_t wr_addr_q;
   word_t     hold_q;

   logic start;
   logic accept;
   logic last_beat;
   logic rd_left;
   logic issue;

   assign start = (state_q == ST_IDLE) && run && (cfg.length != '0) &&
                  ((cfg.dir == DIR_EXT2INT) || (cfg.dir == DIR_INT2EXT));
   assign accept    = valid_q && bus_ready;
   assign last_beat = beat_q == len_t'(cfg.length - 1'b1);
   assign rd_left   = rd_idx_q != cfg.length;

   // Prefetch only when the output slot is free by the next cycle
   assign issue = (state_q == ST_INT2EXT) && rd_left && (!valid_q || bus_ready);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (start) begin
               state_d = (cfg.dir == DIR_EXT2INT) ? ST_EXT2INT : ST_INT2EXT;
            end
         end
         ST_EXT2INT: begin
            // Finish once the last delayed memory write is out
            if (wr_pend_q && !valid_q) begin
               state_d = ST_IDLE;
            end
         end
         ST_INT2EXT: begin
            if (accept && last_beat) begin
               state_d = ST_IDLE;
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         state_q   <= ST_IDLE;
         beat_q    <= '0;
         rd_idx_q  <= '0;
         valid_q   <= 1'b0;
         wr_pend_q <= 1'b0;
         fresh_q   <= 1'b0;
      end else begin
         state_q   <= state_d;
         wr_pend_q <= accept && (state_q == ST_EXT2INT);
         fresh_q   <= issue;
         if (start) begin
            beat_q   <= '0;
            rd_idx_q <= '0;
            valid_q  <= cfg.dir == DIR_EXT2INT;
         end else begin
            if (accept) begin
               beat_q <= beat_q + 1'b1;
            end
            if (issue) begin
               rd_idx_q <= rd_idx_q + 1'b1;
            end
            if (issue) begin
               valid_q <= 1'b1;
            end else if (accept && ((state_q == ST_INT2EXT) || last_beat)) begin
               valid_q <= 1'b0;
            end
         end
      end
   end

   // Write address of the beat just accepted, and the stalled write word
   always_ff @(posedge rst) begin
      if (accept) begin
         wr_addr_q <= cfg.int_addr + beat_q[`DMA_INT_ADDR_W-1:0];
      end
      if (fresh_q) begin
         hold_q <= mem_rdata;
      end
   end

   assign done     = state_q == ST_IDLE;
   assign gen_init = start;
   assign gen_step = accept;

   assign bus_valid = valid_q;
   assign bus_we    = state_q == ST_INT2EXT;
   assign bus_addr  = cfg.ext_addr + ext_offset;

   // Fresh word straight from memory, held copy while stalled
   assign bus_wdata = fresh_q ? mem_rdata : hold_q;

   always_comb begin
      if (state_q == ST_INT2EXT) begin
         mem_req.en    = issue;
         mem_req.we    = 1'b0;
         mem_req.addr  = cfg.int_addr + rd_idx_q[`DMA_INT_ADDR_W-1:0];
         mem_req.wdata = '0;
      end else begin
         mem_req.en    = wr_pend_q;
         mem_req.we    = 1'b1;
         mem_req.addr  = wr_addr_q;
         mem_req.wdata = bus_rdata;
      end
   end

   a_stall_hold: assert property (
      @(posedge rst) disable iff (clk)
      (bus_valid && !bus_ready) |=>
         bus_valid && $stable(bus_addr) && $stable(bus_we) &&
         (!bus_we || $stable(bus_wdata))
   );

   a_idle_quiet: assert property (
      @(posedge rst) disable iff (clk)
      (state_q == ST_IDLE) |-> !bus_valid
   );

endmodule

`default_nettype wire

/* rtl/stride_addr_gen.sv */
`default_nettype none

`include "dma_macros.svh"

module stride_addr_gen
   import dma_pkg::*;
(
   input  wire logic        rst,
   input  wire logic        clk,
   input  wire logic        init,
   input  wire logic        step,
   input  wire stride_cfg_t cfg,
   output ext_addr_t        offset
);

   ext_addr_t offset_q;
   period_t   phase_q;
   logic      shift_en;
   logic      wrap;
   ext_addr_t offset_incr;
   ext_addr_t offset_next;

   // Zero period means the shift never applies
   assign shift_en = cfg.period != '0;

   // Last beat of the current period
   assign wrap = shift_en && (phase_q == period_t'(cfg.period - 1'b1));

   // Signed steps wrap in two's complement at the address width
   assign offset_incr = ext_addr_t'(offset_q + cfg.incr);
   assign offset_next = wrap ? ext_addr_t'(offset_incr + cfg.shift) : offset_incr;

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         offset_q <= '0;
         phase_q  <= '0;
      end else if (init) begin
         offset_q <= cfg.start;
         phase_q  <= '0;
      end else if (step) begin
         offset_q <= offset_next;
         if (wrap) begin
            phase_q <= '0;
         end else if (shift_en) begin
            phase_q <= phase_q + 1'b1;
         end
      end
   end

   assign offset = offset_q;

   // The engine only starts a sequence while no beat is in flight
   a_init_step_excl: assert property (
      @(posedge rst) disable iff (clk)
      !(init && step)
   );

endmodule

`default_nettype wire

/* rtl/dma_pkg.sv */
`default_nettype none

`include "dma_macros.svh"

package dma_pkg;

   typedef logic [`DMA_DATA_W-1:0] word_t;
   typedef logic [`DMA_EXT_ADDR_W-1:0] ext_addr_t;
   typedef logic [`DMA_INT_ADDR_W-1:0] int_addr_t;
   typedef logic signed [`DMA_EXT_ADDR_W-1:0] stride_t;
   typedef logic [`DMA_LEN_W-1:0] len_t;
   typedef logic [`DMA_PERIOD_W-1:0] period_t;

   typedef enum logic [1:0] {
      DIR_NONE    = 2'b00,
      DIR_EXT2INT = 2'b01,
      DIR_INT2EXT = 2'b10
   } dma_dir_e;

   typedef enum logic [1:0] {
      ST_IDLE    = 2'b00,
      ST_EXT2INT = 2'b01,
      ST_INT2EXT = 2'b10
   } xfer_state_e;

   // Offset sequence of the external address generator
   typedef struct packed {
      ext_addr_t start;
      stride_t   incr;
      stride_t   shift;
      period_t   period;
   } stride_cfg_t;

   typedef struct packed {
      ext_addr_t   ext_addr;
      int_addr_t   int_addr;
      len_t        length;
      dma_dir_e    dir;
      stride_cfg_t stride;
   } dma_cfg_t;

   // One request on a memory port
   typedef struct packed {
      logic      en;
      logic      we;
      int_addr_t addr;
      word_t     wdata;
   } mem_req_t;

endpackage

`default_nettype wire

/* include/dma_macros.svh */
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// Data word width
`define DMA_DATA_W 32

// External bus word address width
`define DMA_EXT_ADDR_W 16

// Internal memory address width
`define DMA_INT_ADDR_W 8

// One extra bit so a full internal memory fits in one transfer
`define DMA_LEN_W 9

// Beats between stride shifts
`define DMA_PERIOD_W 8

`endif
